// File: fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// ##########################################################################
// fetch address after reset
// ##########################################################################

`define FETCH_RESET_PC 32'h80000000

// ##########################################################################
// icache geometry, one 32-bit word per line
// ##########################################################################

`define ICACHE_LINES 16
`define ICACHE_IDX_W 4

// device window, inclusive bounds, never cached
`define UNCACHED_LO 32'h0f000000
`define UNCACHED_HI 32'h0f002000

// fence.i word, invalidates the icache when delivered
`define FENCE_I_INST 32'h0000100f

`endif

// File: fetch_pkg.sv
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

  // byte address and instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;

  // index is addr[IDX_W+1:2], tag is everything above it
  typedef logic [`ICACHE_IDX_W-1:0] icache_idx_t;
  typedef logic [(32 - `ICACHE_IDX_W - 2) - 1:0] icache_tag_t;

  // fetch FSM
  typedef enum logic [1:0]
  {
    LOOKUP,
    REQ,
    RESP,
    HOLD
  } fetch_state_e;

endpackage

`default_nettype wire

// File: fetch_pc_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_pc_gen (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   advance_i,
  input  wire                   redirect_valid_i,
  input  wire fetch_pkg::addr_t redirect_pc_i,
  output fetch_pkg::addr_t      pc_o
);

  import fetch_pkg::*;

  addr_t pc_seq;
  addr_t pc_next;

  assign pc_seq = pc_o + 32'd4;

  // redirect only counts on the transfer edge
  always_comb
  begin
    if (redirect_valid_i)
      pc_next = redirect_pc_i;
    else
      pc_next = pc_seq;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_o <= `FETCH_RESET_PC;
    end
    else if (advance_i)
    begin
      pc_o <= pc_next;
    end
  end

  // ##########################################################################
  // checks
  // ##########################################################################

  // redirect targets come from outside, so catch a bad one here
  pc_aligned_a: assert property (
    @(posedge clk) disable iff (rst)
    pc_o[1:0] == 2'b00
  );

endmodule

`default_nettype wire

// File: fetch_icache.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_icache (
  input  wire                   clk,
  input  wire                   rst,
  input  wire fetch_pkg::addr_t lookup_addr_i,
  output logic                  hit_o,
  output fetch_pkg::inst_t      hit_data_o,
  input  wire                   fill_i,
  input  wire fetch_pkg::addr_t fill_addr_i,
  input  wire fetch_pkg::inst_t fill_data_i,
  input  wire                   flush_i
);

  import fetch_pkg::*;

  // ##########################################################################
  // storage
  // ##########################################################################

  inst_t                    data_q [`ICACHE_LINES];
  icache_tag_t              tag_q  [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0] valid_q;

  icache_idx_t lk_idx;
  icache_tag_t lk_tag;
  logic        lk_cacheable;
  icache_idx_t fl_idx;
  icache_tag_t fl_tag;
  logic        fl_cacheable;
  logic        fill_en;

  function automatic logic is_cacheable(addr_t a);
    return (a < `UNCACHED_LO) || (a > `UNCACHED_HI);
  endfunction

  function automatic icache_idx_t idx_of(addr_t a);
    return a[`ICACHE_IDX_W+1:2];
  endfunction

  function automatic icache_tag_t tag_of(addr_t a);
    return a[31:`ICACHE_IDX_W+2];
  endfunction

  // ##########################################################################
  // lookup, purely combinational
  // ##########################################################################

  assign lk_idx       = idx_of(lookup_addr_i);
  assign lk_tag       = tag_of(lookup_addr_i);
  assign lk_cacheable = is_cacheable(lookup_addr_i);

  assign hit_o      = lk_cacheable && valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
  assign hit_data_o = data_q[lk_idx];

  // fill side
  assign fl_idx       = idx_of(fill_addr_i);
  assign fl_tag       = tag_of(fill_addr_i);
  assign fl_cacheable = is_cacheable(fill_addr_i);
  assign fill_en      = fill_i && fl_cacheable;

  // flush beats a fill on the same edge
  always_ff @(posedge clk)
  begin
    if (rst || flush_i)
    begin
      valid_q <= '0;
    end
    else if (fill_en)
    begin
      valid_q[fl_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill_en)
    begin
      data_q[fl_idx] <= fill_data_i;
      tag_q[fl_idx]  <= fl_tag;
    end
  end

  // fence word is never filled, so the unit never raises both
  no_fill_on_flush_a: assert property (
    @(posedge clk) disable iff (rst)
    !(fill_i && flush_i && fl_cacheable)
  );

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_unit (
  input  wire                   clk,
  input  wire                   rst,
  input  wire fetch_pkg::addr_t pc_i,
  input  wire                   hit_i,
  input  wire fetch_pkg::inst_t hit_data_i,
  output logic                  fill_o,
  output fetch_pkg::addr_t      fill_addr_o,
  output fetch_pkg::inst_t      fill_data_o,
  output logic                  flush_o,
  output logic                  advance_o,
  output logic                  ar_valid_o,
  output fetch_pkg::addr_t      ar_addr_o,
  input  wire                   ar_ready_i,
  input  wire                   r_valid_i,
  input  wire fetch_pkg::inst_t r_data_i,
  output logic                  out_valid_o,
  input  wire                   out_ready_i,
  output fetch_pkg::inst_t      out_inst_o,
  output fetch_pkg::addr_t      out_pc_o
);

  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  addr_t        fetch_pc_q;
  inst_t        inst_q;
  logic         resp_fire;
  logic         resp_fence;
  logic         xfer;

  assign resp_fire  = (state_q == RESP) && r_valid_i;
  assign resp_fence = (r_data_i == `FENCE_I_INST);
  assign xfer       = (state_q == HOLD) && out_ready_i;

  // ##########################################################################
  // state machine
  // ##########################################################################

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      LOOKUP:
        state_d = hit_i ? HOLD : REQ;
      REQ:
        if (ar_ready_i)
          state_d = RESP;
      RESP:
        if (r_valid_i)
          state_d = HOLD;
      HOLD:
        if (out_ready_i)
          state_d = LOOKUP;
      default:
        state_d = LOOKUP;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state_q <= LOOKUP;
    else
      state_q <= state_d;
  end

  // pc of the fetch in flight, doubles as bus and fill address
  always_ff @(posedge clk)
  begin
    if (state_q == LOOKUP)
    begin
      fetch_pc_q <= pc_i;
    end
    if ((state_q == LOOKUP) && hit_i)
    begin
      inst_q <= hit_data_i;
    end
    else if (resp_fire)
    begin
      inst_q <= r_data_i;
    end
  end

  // ##########################################################################
  // outputs
  // ##########################################################################

  assign ar_valid_o = (state_q == REQ);
  assign ar_addr_o  = fetch_pc_q;

  // fence word wipes the cache instead of landing in it
  assign fill_o      = resp_fire && !resp_fence;
  assign flush_o     = resp_fire && resp_fence;
  assign fill_addr_o = fetch_pc_q;
  assign fill_data_o = r_data_i;

  assign out_valid_o = (state_q == HOLD);
  assign out_inst_o  = inst_q;
  assign out_pc_o    = fetch_pc_q;
  assign advance_o   = xfer;

  ar_addr_stable_a: assert property (
    @(posedge clk) disable iff (rst)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o)
  );

  out_stable_a: assert property (
    @(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_inst_o) && $stable(out_pc_o)
  );

  // one read outstanding, so a response outside RESP is a slave bug
  r_valid_in_resp_a: assert property (
    @(posedge clk) disable iff (rst)
    r_valid_i |-> state_q == RESP
  );

endmodule

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
  input  wire                   clk,
  input  wire                   rst,
  output logic                  out_valid_o,
  input  wire                   out_ready_i,
  output fetch_pkg::inst_t      out_inst_o,
  output fetch_pkg::addr_t      out_pc_o,
  input  wire                   redirect_valid_i,
  input  wire fetch_pkg::addr_t redirect_pc_i,
  output logic                  ar_valid_o,
  output fetch_pkg::addr_t      ar_addr_o,
  input  wire                   ar_ready_i,
  input  wire                   r_valid_i,
  input  wire fetch_pkg::inst_t r_data_i
);

  import fetch_pkg::*;

  addr_t pc;
  logic  advance;
  logic  hit;
  inst_t hit_data;
  logic  fill;
  addr_t fill_addr;
  inst_t fill_data;
  logic  flush;

  fetch_pc_gen u_pc_gen (
    .clk              (clk),
    .rst              (rst),
    .advance_i        (advance),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .pc_o             (pc)
  );

  fetch_unit u_fetch (
    .clk         (clk),
    .rst         (rst),
    .pc_i        (pc),
    .hit_i       (hit),
    .hit_data_i  (hit_data),
    .fill_o      (fill),
    .fill_addr_o (fill_addr),
    .fill_data_o (fill_data),
    .flush_o     (flush),
    .advance_o   (advance),
    .ar_valid_o  (ar_valid_o),
    .ar_addr_o   (ar_addr_o),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_valid_i),
    .r_data_i    (r_data_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_inst_o  (out_inst_o),
    .out_pc_o    (out_pc_o)
  );

  // lookup runs straight off the pc register
  fetch_icache u_icache (
    .clk           (clk),
    .rst           (rst),
    .lookup_addr_i (pc),
    .hit_o         (hit),
    .hit_data_o    (hit_data),
    .fill_i        (fill),
    .fill_addr_i   (fill_addr),
    .fill_data_i   (fill_data),
    .flush_i       (flush)
  );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // two cycles of reset, released just after an edge
  initial
  begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb_imem.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module tb_imem (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   ar_valid_i,
  input  wire fetch_pkg::addr_t ar_addr_i,
  output logic                  ar_ready_o,
  output logic                  r_valid_o,
  output fetch_pkg::inst_t      r_data_o
);

  import fetch_pkg::*;

  addr_t req_log [$];
  bit    fence_tab [addr_t];

  task automatic add_fence(input addr_t a);
    fence_tab[a] = 1'b1;
  endtask

  function automatic int log_size();
    return req_log.size();
  endfunction

  task automatic pop_req(output addr_t a);
    a = req_log.pop_front();
  endtask

  function automatic inst_t word_at(addr_t a);
    if (fence_tab.exists(a))
      return `FENCE_I_INST;
    return a ^ 32'h5a5a5a5a;
  endfunction

  initial
  begin
    int    delay;
    addr_t addr;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    forever
    begin
      // idle until a request shows up
      do
      begin
        @(posedge clk);
        #1;
      end
      while (rst || !ar_valid_i);
      delay = $urandom_range(3, 0);
      repeat (delay)
      begin
        @(posedge clk);
        #1;
      end
      ar_ready_o = 1'b1;
      addr       = ar_addr_i;
      @(posedge clk);
      #1;
      ar_ready_o = 1'b0;
      req_log.push_back(addr);
      // data comes back at least one edge after the accept
      delay = $urandom_range(5, 1);
      repeat (delay - 1)
      begin
        @(posedge clk);
        #1;
      end
      r_valid_o = 1'b1;
      r_data_o  = word_at(addr);
      @(posedge clk);
      #1;
      r_valid_o = 1'b0;
      r_data_o  = '0;
    end
  end

endmodule

`default_nettype wire

// File: fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;

  import fetch_pkg::*;

  localparam addr_t RESET_PC   = `FETCH_RESET_PC;
  localparam addr_t FENCE_PC   = 32'h80000100;
  localparam addr_t DEVICE_PC  = `UNCACHED_LO + 32'h100;
  localparam int    WAIT_LIMIT = 64;
  // about 80 fetches at up to 16 cycles of 8 ns, with a wide margin
  localparam int    WATCHDOG_NS = 50000;

  wire   clk;
  wire   rst;
  logic  out_valid;
  logic  out_ready;
  inst_t out_inst;
  addr_t out_pc;
  logic  redirect_valid;
  addr_t redirect_pc;
  logic  ar_valid;
  addr_t ar_addr;
  logic  ar_ready;
  logic  r_valid;
  inst_t r_data;

  // shadow of the icache contents
  logic [`ICACHE_LINES-1:0] sh_valid;
  icache_tag_t              sh_tag [`ICACHE_LINES];
  bit                       fence_set [addr_t];
  addr_t                    exp_pc;

  tb_clk_gen u_clk_gen (.clk(clk), .rst(rst));

  tb_imem u_imem (
    .clk        (clk),
    .rst        (rst),
    .ar_valid_i (ar_valid),
    .ar_addr_i  (ar_addr),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data)
  );

  fetch_top dut_i (
    .clk              (clk),
    .rst              (rst),
    .out_valid_o      (out_valid),
    .out_ready_i      (out_ready),
    .out_inst_o       (out_inst),
    .out_pc_o         (out_pc),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .ar_valid_o       (ar_valid),
    .ar_addr_o        (ar_addr),
    .ar_ready_i       (ar_ready),
    .r_valid_i        (r_valid),
    .r_data_i         (r_data)
  );

  // ##########################################################################
  // helpers
  // ##########################################################################

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
      abort_run($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic bit cacheable(addr_t a);
    return (a < `UNCACHED_LO) || (a > `UNCACHED_HI);
  endfunction

  function automatic inst_t mem_word(addr_t a);
    if (fence_set.exists(a))
      return `FENCE_I_INST;
    return a ^ 32'h5a5a5a5a;
  endfunction

  function automatic bit predict_miss(addr_t a);
    icache_idx_t i;
    i = a[`ICACHE_IDX_W+1:2];
    return !cacheable(a) || !sh_valid[i] || (sh_tag[i] != a[31:`ICACHE_IDX_W+2]);
  endfunction

  task automatic shadow_update(input addr_t a, input inst_t w);
    icache_idx_t i;
    i = a[`ICACHE_IDX_W+1:2];
    if (w == `FENCE_I_INST)
      sh_valid = '0;
    else if (cacheable(a))
    begin
      sh_valid[i] = 1'b1;
      sh_tag[i]   = a[31:`ICACHE_IDX_W+2];
    end
  endtask

  task automatic mark_fence(input addr_t a);
    fence_set[a] = 1'b1;
    u_imem.add_fence(a);
  endtask

  // one transfer: wait, stall with a bogus redirect, then hand over
  task automatic fetch_one(input bit redir, input addr_t target, input int min_stall,
                           input int max_stall, output bit missed);
    int    log0;
    int    waited;
    int    stall;
    bit    expect_miss;
    addr_t req_addr;
    inst_t held_inst;
    addr_t held_pc;
    expect_miss = predict_miss(exp_pc);
    log0        = u_imem.log_size();
    waited      = 0;
    while (!out_valid)
    begin
      next_cycle();
      waited++;
      assert (waited < WAIT_LIMIT)
      else
        abort_run("out_valid_o never rose for the next fetch");
    end
    assert (expect_miss || waited == 1)
    else
      abort_run("out_valid_o rose late after a cache hit");
    check_value("out_pc_o", out_pc, exp_pc);
    check_value("out_inst_o", out_inst, mem_word(exp_pc));
    held_inst = out_inst;
    held_pc   = out_pc;
    stall     = $urandom_range(max_stall, min_stall);
    repeat (stall)
    begin
      redirect_valid = 1'b1;
      redirect_pc    = held_pc + 32'h200;
      next_cycle();
      assert (out_valid)
      else
        abort_run("out_valid_o dropped while stalled");
      check_value("out_inst_o", out_inst, held_inst);
      check_value("out_pc_o", out_pc, held_pc);
    end
    out_ready      = 1'b1;
    redirect_valid = redir;
    redirect_pc    = target;
    next_cycle();
    out_ready      = 1'b0;
    redirect_valid = 1'b0;
    missed = (u_imem.log_size() != log0);
    assert (missed == expect_miss)
    else
      abort_run($sformatf("bus request wrong for pc %h, expected one: %0d",
                          held_pc, expect_miss));
    if (missed)
    begin
      check_value("bus request count", u_imem.log_size(), log0 + 1);
      u_imem.pop_req(req_addr);
      check_value("ar_addr_o", req_addr, held_pc);
    end
    shadow_update(held_pc, held_inst);
    exp_pc = redir ? target : held_pc + 32'd4;
  endtask

  // ##########################################################################
  // tests
  // ##########################################################################

  task automatic test_reset();
    do
    begin
      @(negedge clk);
      assert (!out_valid && !ar_valid)
      else
        abort_run("a valid output was high during or right after reset");
    end
    while (rst);
    while (!ar_valid)
      next_cycle();
    check_value("ar_addr_o", ar_addr, RESET_PC);
  endtask

  task automatic test_sequential();
    bit missed;
    for (int i = 0; i < 20; i++)
      fetch_one(i == 19, RESET_PC, 0, 3, missed);
  endtask

  task automatic test_hit_redirect();
    bit missed;
    int misses;
    misses = 0;
    for (int i = 0; i < 16; i++)
      fetch_one(i == 15, RESET_PC, 0, 3, missed);
    // every line is cached now, stalls carry ignored redirects
    for (int i = 0; i < 16; i++)
    begin
      fetch_one(i == 15, RESET_PC + 32'h40, 1, 3, missed);
      if (missed)
        misses++;
    end
    assert (misses == 0)
    else
      abort_run("replay of cached lines went out on the bus");
  endtask

  task automatic test_conflict();
    bit missed;
    fetch_one(1'b1, RESET_PC, 0, 2, missed);
    assert (missed)
    else
      abort_run("line sharing an index with a cached line did not miss");
    fetch_one(1'b1, DEVICE_PC, 0, 2, missed);
    assert (missed)
    else
      abort_run("evicted line did not miss");
  endtask

  task automatic test_uncached();
    bit missed;
    for (int pass = 0; pass < 2; pass++)
    begin
      for (int i = 0; i < 3; i++)
      begin
        fetch_one(i == 2, (pass == 0) ? DEVICE_PC : FENCE_PC, 0, 2, missed);
        assert (missed)
        else
          abort_run("fetch from the device window did not go out on the bus");
      end
    end
  endtask

  task automatic test_fence();
    bit missed;
    fetch_one(1'b1, RESET_PC + 32'h4, 0, 2, missed);
    for (int i = 0; i < 4; i++)
    begin
      fetch_one(i == 3, FENCE_PC, 0, 2, missed);
      assert (missed)
      else
        abort_run("line cached before fence.i still hit after it");
    end
    for (int i = 0; i < 2; i++)
    begin
      fetch_one(1'b1, FENCE_PC, 0, 2, missed);
      assert (missed)
      else
        abort_run("fence.i address hit in the cache");
    end
  endtask

  initial
  begin
    #WATCHDOG_NS;
    abort_run("watchdog expired before the tests finished");
  end

  initial
  begin
    out_ready      = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    sh_valid       = '0;
    exp_pc         = RESET_PC;
    void'($urandom(32'hfdf2));
    mark_fence(FENCE_PC);
    test_reset();
    test_sequential();
    test_hit_redirect();
    test_conflict();
    test_uncached();
    test_fence();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: fetch_top.f
+incdir+.
fetch_pkg.sv
fetch_pc_gen.sv
fetch_icache.sv
fetch_unit.sv
fetch_top.sv
tb_clk_gen.sv
tb_imem.sv
fetch_tb.sv

// File: Makefile
TOP := fetch_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f fetch_top.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "RESULT: PASS"

clean:
	rm -rf obj_dir
